// File: include/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// cache geometry
`define LSU_LINE_WORDS 4
`define LSU_OFFSET_BITS $clog2(`LSU_LINE_WORDS)
`define LSU_INDEX_BITS 4

// word address inside the data array (index plus word offset)
`define LSU_CADDR_BITS (`LSU_INDEX_BITS + `LSU_OFFSET_BITS)

// write buffer entries
`define LSU_WBUF_DEPTH 4

// backing memory size and the byte address width derived from it
`define LSU_MEM_DEPTH_WORDS 4096
`define LSU_MEM_AW ($clog2(`LSU_MEM_DEPTH_WORDS) + 2)
`define LSU_TAG_BITS (`LSU_MEM_AW - `LSU_CADDR_BITS - 2)

`endif

// File: hdl/lsu_pkg.sv
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

  typedef logic [`LSU_MEM_AW-1:0] mem_addr_t;
  typedef logic [`LSU_CADDR_BITS-1:0] cache_addr_t;
  typedef logic [`LSU_INDEX_BITS-1:0] cache_index_t;

  typedef enum logic {
    lsu_op_read  = 1'b0,
    lsu_op_write = 1'b1
  } lsu_op_e;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strobe;
    lsu_op_e     op;
    logic        uncached;
  } lsu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } lsu_resp_t;

  typedef struct packed {
    logic                     valid;
    logic [`LSU_TAG_BITS-1:0] tag;
  } dcache_tag_t;

  typedef struct packed {
    // EX read port
    logic        rvalid;
    cache_addr_t raddr;
    // M2 write port
    logic        we_valid;
    logic        uncached;
    logic [3:0]  strobe;
    logic [31:0] wdata;
    mem_addr_t   addr;
    // M2 refill or uncached read
    logic        op_valid;
    mem_addr_t   op_addr;
  } dm_req_t;

  typedef struct packed {
    logic [31:0] rdata_d1;
    dcache_tag_t tag_d1;
    logic        we_ready;
    logic        op_ready;
    logic [31:0] r_uncached;
    logic        pending_write;
  } dm_resp_t;

  typedef struct packed {
    logic [3:0]   data_we;
    cache_addr_t  data_waddr;
    logic [31:0]  data_wdata;
    logic         tag_we;
    cache_index_t tag_waddr;
    dcache_tag_t  tag_wdata;
  } dm_snoop_t;

  typedef struct packed {
    mem_addr_t   addr;
    logic [31:0] wdata;
    logic [3:0]  strobe;
    logic        write;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } mem_resp_t;

  // address field helpers shared by the pipeline and the cache manager
  function automatic cache_addr_t cache_waddr(mem_addr_t addr);
    return addr[`LSU_CADDR_BITS+1:2];
  endfunction

  function automatic cache_index_t cache_index(mem_addr_t addr);
    return addr[`LSU_CADDR_BITS+1:`LSU_OFFSET_BITS+2];
  endfunction

  function automatic logic [`LSU_TAG_BITS-1:0] cache_tag(mem_addr_t addr);
    return addr[`LSU_MEM_AW-1:`LSU_CADDR_BITS+2];
  endfunction

  function automatic logic tag_hit(dcache_tag_t tag, mem_addr_t addr);
    return tag.valid && (tag.tag == cache_tag(addr));
  endfunction

endpackage

`default_nettype wire

// File: hdl/lsu_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i,
  output logic     empty_o
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  payload_t         buf_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w:0]   count_q;
  logic             push;
  logic             pop;

  function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count_q != (ptr_w+1)'(depth));
  assign out_valid_o = (count_q != '0);
  assign empty_o     = (count_q == '0);
  assign out_data_o  = buf_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (push) begin
      buf_q[wr_ptr_q] <= in_data_i;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/dcache_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module dcache_manager (
  input  logic               clk,
  input  logic               rst_n,
  input  lsu_pkg::dm_req_t   dm_req_i,
  output lsu_pkg::dm_resp_t  dm_resp_o,
  output lsu_pkg::dm_snoop_t dm_snoop_o,
  output logic               mem_req_valid_o,
  output lsu_pkg::mem_req_t  mem_req_o,
  input  logic               mem_req_ready_i,
  input  logic               mem_resp_valid_i,
  input  lsu_pkg::mem_resp_t mem_resp_i,
  output logic               mem_resp_ready_o
);

  localparam int lines = 1 << `LSU_INDEX_BITS;
  localparam int words = lines * `LSU_LINE_WORDS;

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_fill = 2'd1;
  localparam logic [1:0] st_tag  = 2'd2;
  localparam logic [1:0] st_unc  = 2'd3;

  logic [31:0]              data_mem [words];
  logic [`LSU_TAG_BITS-1:0] tag_mem  [lines];
  logic [lines-1:0]         valid_q;
  logic [31:0]              rdata_d1_q;
  lsu_pkg::dcache_tag_t     tag_d1_q;

  logic [1:0]                  state_q;
  logic [1:0]                  state_d;
  logic [`LSU_OFFSET_BITS:0]   req_cnt_q;
  logic [`LSU_OFFSET_BITS-1:0] rsp_cnt_q;

  lsu_pkg::mem_req_t     wbuf_in;
  lsu_pkg::mem_req_t     wbuf_out;
  lsu_pkg::mem_req_t     rd_req;
  logic                  wbuf_ready;
  logic                  wbuf_valid;
  logic                  wbuf_empty;
  lsu_pkg::mem_resp_t    rsp_data;
  logic                  rsp_valid;
  logic                  rsp_take;
  logic                  rsp_pop;
  logic                  rd_pending;
  logic                  rd_fire;
  lsu_pkg::cache_index_t wr_index;
  lsu_pkg::cache_index_t r_index;
  lsu_pkg::cache_index_t op_index;
  lsu_pkg::dcache_tag_t  wr_tag;
  logic                  wr_merge;
  lsu_pkg::dm_snoop_t    snoop;

  assign wbuf_in = '{addr: dm_req_i.addr, wdata: dm_req_i.wdata,
                     strobe: dm_req_i.strobe, write: 1'b1};

  lsu_fifo #(
    .payload_t (lsu_pkg::mem_req_t),
    .depth     (`LSU_WBUF_DEPTH)
  ) u_wbuf (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (dm_req_i.we_valid),
    .in_data_i   (wbuf_in),
    .in_ready_o  (wbuf_ready),
    .out_valid_o (wbuf_valid),
    .out_data_o  (wbuf_out),
    .out_ready_i (mem_req_ready_i),
    .empty_o     (wbuf_empty)
  );

  lsu_fifo #(
    .payload_t (lsu_pkg::mem_resp_t),
    .depth     (`LSU_LINE_WORDS)
  ) u_rsp_q (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (mem_resp_valid_i),
    .in_data_i   (mem_resp_i),
    .in_ready_o  (mem_resp_ready_o),
    .out_valid_o (rsp_valid),
    .out_data_o  (rsp_data),
    .out_ready_i (rsp_take),
    .empty_o     ()
  );

  assign rsp_take = (state_q == st_fill) || (state_q == st_unc);
  assign rsp_pop  = rsp_valid && rsp_take;
  assign op_index = lsu_pkg::cache_index(dm_req_i.op_addr);
  assign r_index  = dm_req_i.raddr[`LSU_CADDR_BITS-1:`LSU_OFFSET_BITS];

  // tag lookup for the write port, decides whether the array is merged
  assign wr_index = lsu_pkg::cache_index(dm_req_i.addr);
  assign wr_tag   = '{valid: valid_q[wr_index], tag: tag_mem[wr_index]};
  assign wr_merge = dm_req_i.we_valid && wbuf_ready && !dm_req_i.uncached &&
                    lsu_pkg::tag_hit(wr_tag, dm_req_i.addr);

  // read requests for refill or uncached load, one word each
  always_comb begin
    rd_pending = ((state_q == st_fill) && (req_cnt_q < `LSU_LINE_WORDS)) ||
                 ((state_q == st_unc) && (req_cnt_q == '0));
    rd_req = '0;
    if (state_q == st_fill) begin
      rd_req.addr = {dm_req_i.op_addr[`LSU_MEM_AW-1:`LSU_OFFSET_BITS+2],
                     req_cnt_q[`LSU_OFFSET_BITS-1:0], 2'b00};
    end else begin
      rd_req.addr = {dm_req_i.op_addr[`LSU_MEM_AW-1:2], 2'b00};
    end
    rd_req.strobe = 4'hf;
  end

  // buffered writes always win the memory port
  assign mem_req_valid_o = wbuf_valid || rd_pending;
  assign mem_req_o       = wbuf_valid ? wbuf_out : rd_req;
  assign rd_fire         = !wbuf_valid && rd_pending && mem_req_ready_i;

  // every array write goes through the snoop record
  always_comb begin
    snoop = '0;
    if (wr_merge) begin
      snoop.data_we    = dm_req_i.strobe;
      snoop.data_waddr = lsu_pkg::cache_waddr(dm_req_i.addr);
      snoop.data_wdata = dm_req_i.wdata;
    end else if ((state_q == st_fill) && rsp_pop) begin
      snoop.data_we    = 4'hf;
      snoop.data_waddr = {op_index, rsp_cnt_q};
      snoop.data_wdata = rsp_data.rdata;
    end
    if (state_q == st_tag) begin
      snoop.tag_we    = 1'b1;
      snoop.tag_waddr = op_index;
      snoop.tag_wdata = '{valid: 1'b1, tag: lsu_pkg::cache_tag(dm_req_i.op_addr)};
    end
  end

  assign dm_snoop_o = snoop;

  always_ff @(posedge clk) begin
    for (int s = 0; s < 4; s++) begin
      if (snoop.data_we[s]) begin
        data_mem[snoop.data_waddr][8*s +: 8] <= snoop.data_wdata[8*s +: 8];
      end
    end
    if (snoop.tag_we) begin
      tag_mem[snoop.tag_waddr] <= snoop.tag_wdata.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (snoop.tag_we) begin
      valid_q[snoop.tag_waddr] <= 1'b1;
    end
  end

  // registered read port, same-cycle array writes are forwarded
  always_ff @(posedge clk) begin
    if (dm_req_i.rvalid) begin
      rdata_d1_q <= data_mem[dm_req_i.raddr];
      tag_d1_q   <= '{valid: valid_q[r_index], tag: tag_mem[r_index]};
      for (int s = 0; s < 4; s++) begin
        if (snoop.data_we[s] && (snoop.data_waddr == dm_req_i.raddr)) begin
          rdata_d1_q[8*s +: 8] <= snoop.data_wdata[8*s +: 8];
        end
      end
      if (snoop.tag_we && (snoop.tag_waddr == r_index)) begin
        tag_d1_q <= snoop.tag_wdata;
      end
    end
  end

  // refill engine, loads wait for the write buffer to drain
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (dm_req_i.op_valid && wbuf_empty) begin
          state_d = dm_req_i.uncached ? st_unc : st_fill;
        end
      end
      st_fill: begin
        if (rsp_pop && (rsp_cnt_q == `LSU_LINE_WORDS - 1)) begin
          state_d = st_tag;
        end
      end
      st_tag: state_d = st_idle;
      default: begin
        if (rsp_pop) begin
          state_d = st_idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= st_idle;
      req_cnt_q <= '0;
      rsp_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == st_idle) begin
        req_cnt_q <= '0;
        rsp_cnt_q <= '0;
      end else begin
        if (rd_fire) begin
          req_cnt_q <= req_cnt_q + 1'b1;
        end
        if (rsp_pop) begin
          rsp_cnt_q <= rsp_cnt_q + 1'b1;
        end
      end
    end
  end

  always_comb begin
    dm_resp_o.rdata_d1      = rdata_d1_q;
    dm_resp_o.tag_d1        = tag_d1_q;
    dm_resp_o.we_ready      = wbuf_ready;
    dm_resp_o.op_ready      = (state_q == st_tag) || ((state_q == st_unc) && rsp_pop);
    dm_resp_o.r_uncached    = rsp_data.rdata;
    dm_resp_o.pending_write = !wbuf_empty;
  end

endmodule

`default_nettype wire

// File: hdl/lsu_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_pipe_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  input  lsu_pkg::lsu_req_t  req_i,
  output logic               req_ready_o,
  output logic               resp_valid_o,
  output lsu_pkg::lsu_resp_t resp_o,
  output lsu_pkg::dm_req_t   dm_req_o,
  input  lsu_pkg::dm_resp_t  dm_resp_i,
  input  lsu_pkg::dm_snoop_t dm_snoop_i
);

  // one-hot M2 states
  localparam logic [4:0] st_normal   = 5'b00001;
  localparam logic [4:0] st_rd_miss  = 5'b00010;
  localparam logic [4:0] st_unc_rd   = 5'b00100;
  localparam logic [4:0] st_wr_wait  = 5'b01000;
  localparam logic [4:0] st_wait_rel = 5'b10000;

  logic                 rdy_q;
  logic                 stall;
  logic                 req_fire;
  logic                 ex_valid_q;
  logic                 m1_valid_q;
  logic                 m1_fresh_q;
  logic                 m2_valid_q;
  lsu_pkg::lsu_req_t    ex_req_q;
  lsu_pkg::lsu_req_t    m1_req_q;
  lsu_pkg::lsu_req_t    m2_req_q;
  lsu_pkg::mem_addr_t   ex_addr;
  lsu_pkg::mem_addr_t   m1_addr;
  lsu_pkg::mem_addr_t   m2_addr;
  logic [31:0]          m1_data_q;
  logic [31:0]          m1_data;
  logic [31:0]          m2_data_q;
  logic [31:0]          m2_data;
  lsu_pkg::dcache_tag_t m1_tag_q;
  lsu_pkg::dcache_tag_t m1_tag;
  lsu_pkg::dcache_tag_t m2_tag_q;
  lsu_pkg::dcache_tag_t m2_tag;
  logic [4:0]           state_q;
  logic [4:0]           state_d;
  logic                 m2_is_rd;
  logic                 m2_hit;
  logic                 m2_free;
  logic                 m2_rd_done;
  logic [31:0]          m2_rdata;
  logic                 wb_valid_q;
  logic [31:0]          wb_rdata_q;

  // overlay of a same-cycle array write onto a held copy
  function automatic logic [31:0] snoop_data(logic [31:0] word,
                                             lsu_pkg::cache_addr_t waddr,
                                             lsu_pkg::dm_snoop_t snp);
    logic [31:0] res;
    res = word;
    for (int s = 0; s < 4; s++) begin
      if (snp.data_we[s] && (snp.data_waddr == waddr)) begin
        res[8*s +: 8] = snp.data_wdata[8*s +: 8];
      end
    end
    return res;
  endfunction

  function automatic lsu_pkg::dcache_tag_t snoop_tag(lsu_pkg::dcache_tag_t tag,
                                                     lsu_pkg::cache_index_t index,
                                                     lsu_pkg::dm_snoop_t snp);
    return (snp.tag_we && (snp.tag_waddr == index)) ? snp.tag_wdata : tag;
  endfunction

  assign ex_addr = ex_req_q.addr[`LSU_MEM_AW-1:0];
  assign m1_addr = m1_req_q.addr[`LSU_MEM_AW-1:0];
  assign m2_addr = m2_req_q.addr[`LSU_MEM_AW-1:0];

  assign req_ready_o = rdy_q && !stall;
  assign req_fire    = req_valid_i && req_ready_o;

  // M1 takes the array read once, then tracks snooped writes
  assign m1_data = snoop_data(m1_fresh_q ? dm_resp_i.rdata_d1 : m1_data_q,
                              lsu_pkg::cache_waddr(m1_addr), dm_snoop_i);
  assign m1_tag  = snoop_tag(m1_fresh_q ? dm_resp_i.tag_d1 : m1_tag_q,
                             lsu_pkg::cache_index(m1_addr), dm_snoop_i);

  always_comb begin
    if ((state_q == st_unc_rd) && dm_resp_i.op_ready) begin
      m2_data = dm_resp_i.r_uncached;
    end else begin
      m2_data = snoop_data(m2_data_q, lsu_pkg::cache_waddr(m2_addr), dm_snoop_i);
    end
  end

  assign m2_tag   = snoop_tag(m2_tag_q, lsu_pkg::cache_index(m2_addr), dm_snoop_i);
  assign m2_hit   = lsu_pkg::tag_hit(m2_tag_q, m2_addr);
  assign m2_is_rd = (m2_req_q.op == lsu_pkg::lsu_op_read);

  // M2 state machine, stall whenever the entry cannot leave
  always_comb begin
    state_d = state_q;
    m2_free = 1'b0;
    case (state_q)
      st_normal: begin
        if (!m2_valid_q) begin
          m2_free = 1'b1;
        end else if (!m2_is_rd) begin
          if (dm_resp_i.we_ready) begin
            m2_free = 1'b1;
          end else begin
            state_d = st_wr_wait;
          end
        end else if (m2_req_q.uncached) begin
          state_d = st_unc_rd;
        end else if (!m2_hit) begin
          state_d = st_rd_miss;
        end else begin
          m2_free = 1'b1;
        end
      end
      st_rd_miss, st_unc_rd: begin
        if (dm_resp_i.op_ready) begin
          state_d = st_wait_rel;
        end
      end
      st_wr_wait: begin
        if (dm_resp_i.we_ready) begin
          m2_free = 1'b1;
          state_d = st_normal;
        end
      end
      st_wait_rel: begin
        m2_free = 1'b1;
        state_d = st_normal;
      end
      default: state_d = st_normal;
    endcase
  end

  assign stall      = !m2_free;
  assign m2_rd_done = m2_valid_q && m2_is_rd && m2_free;

  // bytes outside the strobe read as zero
  always_comb begin
    for (int s = 0; s < 4; s++) begin
      m2_rdata[8*s +: 8] = m2_req_q.strobe[s] ? m2_data_q[8*s +: 8] : 8'h00;
    end
  end

  always_comb begin
    dm_req_o.rvalid   = ex_valid_q && !stall;
    dm_req_o.raddr    = lsu_pkg::cache_waddr(ex_addr);
    dm_req_o.we_valid = m2_valid_q && !m2_is_rd &&
                        ((state_q == st_normal) || (state_q == st_wr_wait));
    dm_req_o.uncached = m2_req_q.uncached;
    dm_req_o.strobe   = m2_req_q.strobe;
    dm_req_o.wdata    = m2_req_q.wdata;
    dm_req_o.addr     = m2_addr;
    dm_req_o.op_valid = (state_q & (st_rd_miss | st_unc_rd)) != '0;
    dm_req_o.op_addr  = m2_addr;
  end

  // stage payloads
  always_ff @(posedge clk) begin
    m1_data_q <= m1_data;
    m1_tag_q  <= m1_tag;
    if (!stall) begin
      if (req_fire) begin
        ex_req_q <= req_i;
      end
      m1_req_q  <= ex_req_q;
      m2_req_q  <= m1_req_q;
      m2_data_q <= m1_data;
      m2_tag_q  <= m1_tag;
    end else begin
      m2_data_q <= m2_data;
      m2_tag_q  <= m2_tag;
    end
    if (m2_rd_done) begin
      wb_rdata_q <= m2_rdata;
    end
  end

  // stage valids and control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy_q      <= 1'b0;
      ex_valid_q <= 1'b0;
      m1_valid_q <= 1'b0;
      m1_fresh_q <= 1'b0;
      m2_valid_q <= 1'b0;
      wb_valid_q <= 1'b0;
      state_q    <= st_normal;
    end else begin
      rdy_q      <= 1'b1;
      state_q    <= state_d;
      wb_valid_q <= m2_rd_done;
      m1_fresh_q <= ex_valid_q && !stall;
      if (!stall) begin
        ex_valid_q <= req_fire;
        m1_valid_q <= ex_valid_q;
        m2_valid_q <= m1_valid_q;
      end
    end
  end

  assign resp_valid_o = wb_valid_q;
  assign resp_o.rdata = wb_rdata_q;

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  input  lsu_pkg::lsu_req_t  req_i,
  output logic               req_ready_o,
  output logic               resp_valid_o,
  output lsu_pkg::lsu_resp_t resp_o,
  output logic               mem_req_valid_o,
  output lsu_pkg::mem_req_t  mem_req_o,
  input  logic               mem_req_ready_i,
  input  logic               mem_resp_valid_i,
  input  lsu_pkg::mem_resp_t mem_resp_i,
  output logic               mem_resp_ready_o
);

  lsu_pkg::dm_req_t   dm_req;
  lsu_pkg::dm_resp_t  dm_resp;
  lsu_pkg::dm_snoop_t dm_snoop;

  // stage tracking and result ordering
  lsu_pipe_ctrl u_pipe_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .dm_req_o     (dm_req),
    .dm_resp_i    (dm_resp),
    .dm_snoop_i   (dm_snoop)
  );

  // arrays, write buffer and memory port
  dcache_manager u_dcache_manager (
    .clk              (clk),
    .rst_n            (rst_n),
    .dm_req_i         (dm_req),
    .dm_resp_o        (dm_resp),
    .dm_snoop_o       (dm_snoop),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_o        (mem_req_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_i       (mem_resp_i),
    .mem_resp_ready_o (mem_resp_ready_o)
  );

endmodule

`default_nettype wire

// File: sim/lsu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
  input logic              clk,
  input logic              rst_n,
  input logic              req_ready_i,
  input logic              resp_valid_i,
  input logic              mem_req_valid_i,
  input lsu_pkg::mem_req_t mem_req_i,
  input logic              mem_req_ready_i
);

  logic in_reset_q;

  // reset level seen at the previous edge
  always_ff @(posedge clk) begin
    in_reset_q <= !rst_n;
  end

  // second and later reset cycles, registers are cleared by then
  a_no_resp_in_reset: assert property (@(posedge clk)
    (!rst_n && in_reset_q) |-> !resp_valid_i)
    else $error("result valid while reset is asserted");

  // memory request held while stalled by the memory
  a_mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_valid_i && !mem_req_ready_i) |=> (mem_req_valid_i && $stable(mem_req_i)))
    else $error("memory request changed or dropped before it was accepted");

  a_ready_low_after_reset: assert property (@(posedge clk)
    (rst_n && in_reset_q) |-> !req_ready_i)
    else $error("request ready high in the first cycle after reset");

endmodule

`default_nettype wire

// File: sim/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module tb_lsu_top;

  typedef struct packed {
    lsu_pkg::lsu_op_e op;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic [3:0]       strobe;
    logic             uncached;
    logic [31:0]      rdata;
  } stim_t;

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  lsu_pkg::lsu_req_t  req;
  logic               req_ready;
  logic               resp_valid;
  lsu_pkg::lsu_resp_t resp;
  logic               mem_req_valid;
  lsu_pkg::mem_req_t  mem_req;
  logic               mem_req_ready;
  logic               mem_resp_valid;
  lsu_pkg::mem_resp_t mem_resp;
  logic               mem_resp_ready;

  stim_t              stim_q[$];
  string              name_q[$];
  lsu_pkg::lsu_resp_t exp_resp_q[$];
  string              exp_name_q[$];
  lsu_pkg::mem_req_t  exp_wr_q[$];
  string              wr_name_q[$];
  logic [31:0]        rsp_data_q[$];
  logic [31:0]        mem [`LSU_MEM_DEPTH_WORDS];
  int                 wr_total;
  int                 wr_seen;
  int                 cycle_cnt;
  int                 cycle_limit;

  lsu_top u_lsu_top (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_valid_i      (req_valid),
    .req_i            (req),
    .req_ready_o      (req_ready),
    .resp_valid_o     (resp_valid),
    .resp_o           (resp),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_o        (mem_req),
    .mem_req_ready_i  (mem_req_ready),
    .mem_resp_valid_i (mem_resp_valid),
    .mem_resp_i       (mem_resp),
    .mem_resp_ready_o (mem_resp_ready)
  );

  bind lsu_top lsu_checker u_lsu_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_ready_i     (req_ready_o),
    .resp_valid_i    (resp_valid_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_i       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i)
  );

  // power-on content of backing memory
  function automatic logic [31:0] init_word(logic [31:0] addr);
    return (addr >> 2) ^ 32'h5a5a0000;
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic abort_run(string why);
    $display("sim failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_resp(string name, lsu_pkg::lsu_resp_t exp, lsu_pkg::lsu_resp_t act);
    if (act !== exp) begin
      $display("** Error %s: expected rdata %08h, actual %08h", name, exp.rdata, act.rdata);
      abort_run("load result mismatch");
    end
  endtask

  task automatic check_mem(string name, lsu_pkg::mem_req_t exp, lsu_pkg::mem_req_t act);
    if (act !== exp) begin
      $display("** Error %s: expected addr %h data %08h strobe %b, actual addr %h data %08h %s",
               name, exp.addr, exp.wdata, exp.strobe, act.addr, act.wdata,
               $sformatf("strobe %b write %b", act.strobe, act.write));
      abort_run("memory write mismatch");
    end
  endtask

  task automatic read_step(string name, logic [31:0] addr, logic [3:0] strobe, logic unc,
                           logic [31:0] exp);
    stim_q.push_back('{op: lsu_pkg::lsu_op_read, addr: addr, wdata: 32'h0, strobe: strobe,
                       uncached: unc, rdata: exp});
    name_q.push_back(name);
  endtask

  task automatic write_step(string name, logic [31:0] addr, logic [31:0] wdata,
                            logic [3:0] strobe, logic unc);
    stim_q.push_back('{op: lsu_pkg::lsu_op_write, addr: addr, wdata: wdata, strobe: strobe,
                       uncached: unc, rdata: 32'h0});
    name_q.push_back(name);
  endtask

  task automatic burst_step(logic [31:0] addr, logic [31:0] exp);
    read_step($sformatf("burst_%04h", addr[15:0]), addr, 4'hf, 1'b0, exp);
  endtask

  task automatic build_table();
    logic [31:0] merged;
    // miss with refill, then a hit in the same line
    read_step("miss_refill", 32'h0104, 4'hf, 1'b0, init_word(32'h0104));
    read_step("hit_same_line", 32'h0108, 4'hf, 1'b0, init_word(32'h0108));
    // partial write into a present line, seen by cache and memory
    merged = merge_bytes(init_word(32'h0100), 32'hdeadbeef, 4'b0011);
    write_step("write_merge", 32'h0100, 32'hdeadbeef, 4'b0011, 1'b0);
    read_step("read_merged", 32'h0100, 4'hf, 1'b0, merged);
    read_step("unc_read_merged", 32'h0100, 4'hf, 1'b1, merged);
    // no write-allocate, refill after the buffer drains
    write_step("write_no_alloc", 32'h0a20, 32'h12345678, 4'hf, 1'b0);
    read_step("read_after_write_miss", 32'h0a20, 4'hf, 1'b0, 32'h12345678);
    // uncached round trip
    write_step("unc_write", 32'h0c30, 32'hcafe0001, 4'hf, 1'b1);
    read_step("unc_read_back", 32'h0c30, 4'hf, 1'b1, 32'hcafe0001);
    read_step("miss_other_line", 32'h0d40, 4'hf, 1'b0, init_word(32'h0d40));
    read_step("upper_half", 32'h0104, 4'b1100, 1'b0,
              merge_bytes(32'h0, init_word(32'h0104), 4'b1100));
    // hits and misses back to back, 0x1100 evicts line 0x0100
    burst_step(32'h0108, init_word(32'h0108));
    burst_step(32'h0e50, init_word(32'h0e50));
    burst_step(32'h0e54, init_word(32'h0e54));
    burst_step(32'h010c, init_word(32'h010c));
    burst_step(32'h0f60, init_word(32'h0f60));
    burst_step(32'h0a24, init_word(32'h0a24));
    burst_step(32'h0e58, init_word(32'h0e58));
    burst_step(32'h0f6c, init_word(32'h0f6c));
    burst_step(32'h1070, init_word(32'h1070));
    burst_step(32'h1100, init_word(32'h1100));
    burst_step(32'h0100, merged);
    burst_step(32'h0a20, 32'h12345678);
    burst_step(32'h1074, init_word(32'h1074));
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if ((cycle_limit > 0) && (cycle_cnt > cycle_limit)) begin
        $display("timeout: the LSU made no progress within %0d cycles", cycle_limit);
        abort_run("timeout");
      end
    end
  end

  // backing memory with random ready and response delays
  initial begin : mem_model
    lsu_pkg::mem_req_t req_s;
    logic              req_hs;
    logic              rsp_hs;
    int                req_wait;
    int                rsp_wait;
    int                widx;
    void'($urandom(32'h3db1));
    for (int a = 0; a < `LSU_MEM_DEPTH_WORDS; a++) begin
      mem[a] = a ^ 32'h5a5a0000;
    end
    wr_seen        = 0;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp       = '0;
    req_wait       = $urandom % 4;
    rsp_wait       = 0;
    forever begin
      @(posedge clk);
      req_hs = rst_n && mem_req_valid && mem_req_ready;
      rsp_hs = rst_n && mem_resp_valid && mem_resp_ready;
      req_s  = mem_req;
      #1;
      if (rsp_hs) begin
        void'(rsp_data_q.pop_front());
        rsp_wait = $urandom % 4;
      end else if ((rsp_data_q.size() != 0) && (rsp_wait > 0)) begin
        rsp_wait--;
      end
      if (req_hs) begin
        widx = int'(req_s.addr[`LSU_MEM_AW-1:2]);
        if (req_s.write) begin
          wr_seen++;
          if (exp_wr_q.size() == 0) begin
            $display("memory write to %h with no write left in the table", req_s.addr);
            abort_run("unexpected memory write");
          end else begin
            check_mem(wr_name_q.pop_front(), exp_wr_q.pop_front(), req_s);
          end
          mem[widx] = merge_bytes(mem[widx], req_s.wdata, req_s.strobe);
        end else begin
          if (rsp_data_q.size() == 0) begin
            rsp_wait = $urandom % 4;
          end
          rsp_data_q.push_back(mem[widx]);
        end
        req_wait = $urandom % 4;
      end else if (req_wait > 0) begin
        req_wait--;
      end
      mem_req_ready  = (req_wait == 0);
      mem_resp_valid = (rsp_data_q.size() != 0) && (rsp_wait == 0);
      mem_resp.rdata = (rsp_data_q.size() != 0) ? rsp_data_q[0] : 32'h0;
    end
  end

  // results come back in request order
  initial begin
    forever begin
      @(posedge clk);
      if (rst_n && resp_valid) begin
        if (exp_resp_q.size() == 0) begin
          $display("load result seen with no read outstanding");
          abort_run("unexpected load result");
        end else begin
          check_resp(exp_name_q.pop_front(), exp_resp_q.pop_front(), resp);
        end
      end
    end
  end

  initial begin
    cycle_limit = 0;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    build_table();
    wr_total = 0;
    for (int i = 0; i < stim_q.size(); i++) begin
      if (stim_q[i].op == lsu_pkg::lsu_op_read) begin
        exp_resp_q.push_back('{rdata: stim_q[i].rdata});
        exp_name_q.push_back(name_q[i]);
      end else begin
        exp_wr_q.push_back('{addr: stim_q[i].addr[`LSU_MEM_AW-1:0], wdata: stim_q[i].wdata,
                             strobe: stim_q[i].strobe, write: 1'b1});
        wr_name_q.push_back(name_q[i]);
        wr_total++;
      end
    end
    cycle_limit = 60 * (stim_q.size() + 1);
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < stim_q.size(); i++) begin
      req_valid = 1'b1;
      req = '{addr: stim_q[i].addr, wdata: stim_q[i].wdata, strobe: stim_q[i].strobe,
              op: stim_q[i].op, uncached: stim_q[i].uncached};
      @(posedge clk);
      while (!req_ready) begin
        @(posedge clk);
      end
      #1;
    end
    req_valid = 1'b0;
    req       = '0;
    while (exp_resp_q.size() != 0) begin
      @(posedge clk);
    end
    // buffered writes still draining to memory
    @(posedge clk);
    while (mem_req_valid) begin
      @(posedge clk);
    end
    if (wr_seen != wr_total) begin
      $display("** Error write_traffic: expected %0d memory writes, actual %0d",
               wr_total, wr_seen);
      abort_run("memory write count mismatch");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_fifo.sv
hdl/dcache_manager.sv
hdl/lsu_pipe_ctrl.sv
hdl/lsu_top.sv
sim/lsu_checker.sv
sim/tb_lsu_top.sv

// File: Bender.yml
package:
  name: lsu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_fifo.sv
      - hdl/dcache_manager.sv
      - hdl/lsu_pipe_ctrl.sv
      - hdl/lsu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/lsu_checker.sv
      - sim/tb_lsu_top.sv
